// File: cpu_stim.txt
// Header: program length, store count. Program lines: reads-previous-load flag, word
// Store lines in program order: address, data
f 5
0 f8404041         // LDUR X1, [X2, #4]
1 8b040023         // ADD  X3, X1, X4
0 aa010065         // ORR  X5, X3, X1
0 f8008005         // STUR X5, [X0, #8]
0 8a0700a6         // AND  X6, X5, X7
0 cb0900c8         // SUB  X8, X6, X9
0 8b06010a         // ADD  X10, X8, X6
0 f800d10a         // STUR X10, [X8, #13]
0 8b05007f         // ADD  XZR, X3, X5
0 f81ff19f         // STUR XZR, [X12, #-1]
0 f840710d         // LDUR X13, [X8, #7]
1 cb0101ae         // SUB  X14, X13, X1
0 f80001ae         // STUR X14, [X13, #0]
0 f840800f         // LDUR X15, [X0, #8]
1 f801000f         // STUR X15, [X0, #16]
8 3e
a 3
b 0
14 fffffffffffffff6
10 3e

// File: compile.f
+incdir+.
cpu_pkg.sv
cpu_fetch.sv
reg_file.sv
cpu_decode.sv
cpu_execute.sv
cpu_result.sv
cpu_top.sv
tb_cpu.sv

// File: run.sh
#!/bin/sh
# Build the testbench with Verilator and run it from the project root
cd "$(dirname "$0")" &&
  verilator --binary --top-module tb_cpu -f compile.f -o Vtb_cpu &&
  ./obj_dir/Vtb_cpu ||
  exit 1

// File: tb_cpu.sv
`timescale 1ns/10ps

module tb_cpu import cpu_pkg::*; ();

  localparam int STIM_DEPTH = 64;

  logic     CLOCK       = 1'b0;
  logic     RESET;
  instr_t   instr       = '0;
  logic     instr_valid = 1'b0;
  word_t    pc;
  logic     fetch_ready;
  mem_req_t mem_req;
  word_t    mem_rdata;

  logic [63:0] stim [STIM_DEPTH];
  word_t       dmem [32];
  int          prog_len;
  int          n_stores;
  int          store_idx;
  int          cycles;
  int          limit;
  word_t       exp_pc;
  int          if_slot;    // Program index in IF/ID or -1 for a bubble
  int          ex_slot;    // Program index in ID/EX
  logic        exp_ready;

  cpu_top UUT (
    .CLOCK       (CLOCK),
    .RESET       (RESET),
    .instr       (instr),
    .instr_valid (instr_valid),
    .pc          (pc),
    .fetch_ready (fetch_ready),
    .mem_req     (mem_req),
    .mem_rdata   (mem_rdata)
  );

  assign mem_rdata = dmem[mem_req.addr[4:0]];  // Answers in the same cycle

  always #50 CLOCK = ~CLOCK;

  function automatic instr_t word_at(input word_t addr);
    int idx;
    idx = int'(addr >> 2);
    if (idx < prog_len)
      return instr_t'(stim[3 + 2 * idx]);
    return '0;  // NOP past the end
  endfunction

  // Program flags mark an instruction that reads the load right before it
  function automatic logic load_use(input int user_slot, input int load_slot);
    if (user_slot < 0 || user_slot >= prog_len || load_slot < 0 || load_slot != user_slot - 1)
      return 1'b0;
    return stim[2 + 2 * user_slot][0];
  endfunction

  task automatic report_failure(input string why);
    $display("%s", why);
    $display("TEST FAIL");
    $fatal(1, "Simulation stopped on error");
  endtask

  task automatic check_store(input mem_req_t req);
    word_t exp_addr;
    word_t exp_data;
    if (store_idx >= n_stores) begin
      report_failure($sformatf("Unexpected store to address %h", req.addr));
    end else begin
      exp_addr = stim[2 + 2 * prog_len + 2 * store_idx];
      exp_data = stim[3 + 2 * prog_len + 2 * store_idx];
      if (req.addr !== exp_addr || req.wdata !== exp_data)
        report_failure($sformatf("MISMATCH at %0t: store %0d expected [%h] = %h, got [%h] = %h",
                                 $time, store_idx, exp_addr, exp_data, req.addr, req.wdata));
      store_idx++;
    end
  endtask

  task automatic check_pc(input word_t act);
    if (act !== exp_pc)
      report_failure($sformatf("MISMATCH at %0t: pc expected %h, got %h", $time, exp_pc, act));
  endtask

  task automatic check_flag(input string what, input logic exp, input logic act);
    if (act !== exp)
      report_failure($sformatf("MISMATCH at %0t: %s expected %b, got %b", $time, what, exp, act));
  endtask

  initial begin
    RESET <= 1'b1;
    void'($urandom(55));
    $readmemh("cpu_stim.txt", stim);
    prog_len = int'(stim[0]);
    n_stores = int'(stim[1]);
    limit    = 4 * prog_len + 64;
    repeat (10) @(posedge CLOCK);
    RESET <= 1'b0;
  end

  always @(posedge CLOCK) begin
    if (RESET) begin
      for (int i = 0; i < 32; i++)
        dmem[i] <= word_t'(5 * i);
      exp_pc      = '0;
      if_slot     = -1;
      ex_slot     = -1;
      exp_ready   = 1'b1;
      store_idx   = 0;
      cycles      = 0;
      instr_valid <= 1'b0;
      instr       <= '0;
    end else begin
      if (cycles == 0) begin
        check_flag("mem_req.read after reset", 1'b0, mem_req.read);
        check_flag("mem_req.write after reset", 1'b0, mem_req.write);
      end
      check_pc(pc);
      check_flag("fetch_ready", exp_ready, fetch_ready);
      if (mem_req.write === 1'b1) begin
        check_store(mem_req);
        dmem[mem_req.addr[4:0]] <= mem_req.wdata;
      end
      if (!exp_ready) begin
        ex_slot = -1;  // Bubble while IF/ID and PC hold
      end else begin
        ex_slot = if_slot;
        if_slot = instr_valid ? int'(exp_pc >> 2) : -1;
        if (instr_valid)
          exp_pc = exp_pc + word_t'(4);
      end
      exp_ready = !load_use(if_slot, ex_slot);
      instr_valid <= ($urandom % 4) != 0;  // Valid three cycles in four
      instr       <= word_at(exp_pc);
      cycles++;
      if (store_idx == n_stores) begin
        $display("TEST PASS");
        $finish;
      end else if (cycles >= limit) begin
        report_failure($sformatf("Timeout after %0d cycles with %0d of %0d stores seen",
                                 cycles, store_idx, n_stores));
      end
    end
  end

endmodule

// File: cpu_top.sv
`timescale 1ns/10ps

module cpu_top import cpu_pkg::*; (
  input  logic     CLOCK,
  input  logic     RESET,
  input  instr_t   instr,
  input  logic     instr_valid,
  output word_t    pc,
  output logic     fetch_ready,
  output mem_req_t mem_req,
  input  word_t    mem_rdata
);

  instr_t   if_instr;
  logic     if_valid;
  logic     stall;
  id_ex_t   id_ex;
  wb_t      wb;
  reg_idx_t ex_rd;
  logic     ex_reg_write;
  logic     ex_mem_to_reg;
  logic     ex_is_load;
  reg_idx_t ex_load_rd;

  cpu_fetch u_fetch (
    .CLOCK       (CLOCK),
    .RESET       (RESET),
    .instr       (instr),
    .instr_valid (instr_valid),
    .stall       (stall),
    .pc          (pc),
    .fetch_ready (fetch_ready),
    .if_instr    (if_instr),
    .if_valid    (if_valid)
  );

  cpu_decode u_decode (
    .CLOCK      (CLOCK),
    .RESET      (RESET),
    .if_instr   (if_instr),
    .if_valid   (if_valid),
    .wb         (wb),
    .ex_is_load (ex_is_load),
    .ex_load_rd (ex_load_rd),
    .stall      (stall),
    .id_ex      (id_ex)
  );

  cpu_execute u_execute (
    .CLOCK         (CLOCK),
    .RESET         (RESET),
    .id_ex         (id_ex),
    .wb            (wb),
    .mem_req       (mem_req),
    .ex_rd         (ex_rd),
    .ex_reg_write  (ex_reg_write),
    .ex_mem_to_reg (ex_mem_to_reg),
    .ex_is_load    (ex_is_load),
    .ex_load_rd    (ex_load_rd)
  );

  cpu_result u_result (
    .CLOCK         (CLOCK),
    .RESET         (RESET),
    .mem_req       (mem_req),
    .mem_rdata     (mem_rdata),
    .ex_rd         (ex_rd),
    .ex_reg_write  (ex_reg_write),
    .ex_mem_to_reg (ex_mem_to_reg),
    .wb            (wb)
  );

endmodule

// File: cpu_result.sv
`timescale 1ns/10ps

module cpu_result import cpu_pkg::*; (
  input  logic     CLOCK,
  input  logic     RESET,
  input  mem_req_t mem_req,
  input  word_t    mem_rdata,
  input  reg_idx_t ex_rd,
  input  logic     ex_reg_write,
  input  logic     ex_mem_to_reg,
  output wb_t      wb
);

  word_t    alu_q;
  word_t    rdata_q;
  reg_idx_t rd_q;
  logic     reg_write_q;
  logic     mem_to_reg_q;

  always_ff @(posedge CLOCK) begin
    if (RESET) begin
      reg_write_q  <= 1'b0;
      mem_to_reg_q <= 1'b0;
    end else begin
      reg_write_q  <= ex_reg_write;
      mem_to_reg_q <= ex_mem_to_reg;
    end
    alu_q   <= mem_req.addr;
    rdata_q <= mem_rdata;   // Memory answers in the same cycle
    rd_q    <= ex_rd;
  end

  assign wb = '{reg_write: reg_write_q,
                rd:        rd_q,
                data:      mem_to_reg_q ? rdata_q : alu_q};

endmodule

// File: cpu_execute.sv
`timescale 1ns/10ps

`include "cpu_params.svh"

module cpu_execute import cpu_pkg::*; (
  input  logic     CLOCK,
  input  logic     RESET,
  input  id_ex_t   id_ex,
  input  wb_t      wb,
  output mem_req_t mem_req,
  output reg_idx_t ex_rd,
  output logic     ex_reg_write,
  output logic     ex_mem_to_reg,
  output logic     ex_is_load,
  output reg_idx_t ex_load_rd
);

  word_t op_a;
  word_t op_b_reg;
  word_t op_b;
  word_t alu_y;

  // Writeback is checked first and wins when both stages match
  function automatic word_t forward(input reg_idx_t idx, input word_t stage_val);
    word_t val;
    val = stage_val;
    if (wb.reg_write && wb.rd != reg_idx_t'(`CPU_XZR) && wb.rd == idx)
      val = wb.data;
    else if (ex_reg_write && ex_rd != reg_idx_t'(`CPU_XZR) && ex_rd == idx)
      val = mem_req.addr;
    return val;
  endfunction

  always_comb begin
    op_a     = forward(id_ex.rn_idx, id_ex.rn_data);
    op_b_reg = forward(id_ex.rm_idx, id_ex.rm_data);
    op_b     = id_ex.ctrl.use_imm ? id_ex.imm : op_b_reg;
    case (id_ex.ctrl.alu_op)
      ALU_SUB: alu_y = op_a - op_b;
      ALU_AND: alu_y = op_a & op_b;
      ALU_ORR: alu_y = op_a | op_b;
      default: alu_y = op_a + op_b;
    endcase
  end

  // Hazard info for decode
  assign ex_is_load = id_ex.valid && id_ex.ctrl.mem_read;
  assign ex_load_rd = id_ex.rd;

  always_ff @(posedge CLOCK) begin
    if (RESET) begin
      mem_req.read  <= 1'b0;
      mem_req.write <= 1'b0;
      ex_reg_write  <= 1'b0;
      ex_mem_to_reg <= 1'b0;
    end else begin
      mem_req.read  <= id_ex.ctrl.mem_read;
      mem_req.write <= id_ex.ctrl.mem_write;
      ex_reg_write  <= id_ex.ctrl.reg_write;
      ex_mem_to_reg <= id_ex.ctrl.mem_to_reg;
    end
    mem_req.addr  <= alu_y;
    mem_req.wdata <= op_b_reg;  // Forwarded store data
    ex_rd         <= id_ex.rd;
  end

endmodule

// File: cpu_decode.sv
`timescale 1ns/10ps

`include "cpu_params.svh"

module cpu_decode import cpu_pkg::*; (
  input  logic     CLOCK,
  input  logic     RESET,
  input  instr_t   if_instr,
  input  logic     if_valid,
  input  wb_t      wb,
  input  logic     ex_is_load,
  input  reg_idx_t ex_load_rd,
  output logic     stall,
  output id_ex_t   id_ex
);

  localparam opcode_t OPC_LDUR = 11'b11111000010;
  localparam opcode_t OPC_STUR = 11'b11111000000;
  localparam opcode_t OPC_ADD  = 11'b10001011000;
  localparam opcode_t OPC_SUB  = 11'b11001011000;
  localparam opcode_t OPC_AND  = 11'b10001010000;
  localparam opcode_t OPC_ORR  = 11'b10101010000;

  opcode_t  opcode;
  ctrl_t    ctrl;
  logic     reads_rn;
  logic     reads_rm;
  reg_idx_t rn_idx;
  reg_idx_t rm_idx;
  word_t    rn_data;
  word_t    rm_data;
  word_t    imm;
  id_ex_t   id_ex_d;

  assign opcode = if_instr[31:21];
  assign rn_idx = if_instr[9:5];
  assign rm_idx = (opcode == OPC_STUR) ? if_instr[4:0] : if_instr[20:16];
  assign imm    = {{(`CPU_XLEN-9){if_instr[20]}}, if_instr[20:12]};

  reg_file u_regs (
    .CLOCK  (CLOCK),
    .RESET  (RESET),
    .rd_a   (rn_idx),
    .rd_b   (rm_idx),
    .wb     (wb),
    .data_a (rn_data),
    .data_b (rm_data)
  );

  always_comb begin
    ctrl     = '0;
    reads_rn = 1'b1;
    reads_rm = 1'b0;
    case (opcode)
      OPC_ADD, OPC_SUB, OPC_AND, OPC_ORR: begin
        ctrl.reg_write = 1'b1;
        reads_rm       = 1'b1;
      end
      OPC_LDUR: begin
        ctrl.use_imm    = 1'b1;
        ctrl.mem_read   = 1'b1;
        ctrl.reg_write  = 1'b1;
        ctrl.mem_to_reg = 1'b1;
      end
      OPC_STUR: begin
        ctrl.use_imm   = 1'b1;
        ctrl.mem_write = 1'b1;
        reads_rm       = 1'b1;  // Store data from Rt
      end
      default: reads_rn = 1'b0; // NOP
    endcase
    case (opcode)
      OPC_SUB: ctrl.alu_op = ALU_SUB;
      OPC_AND: ctrl.alu_op = ALU_AND;
      OPC_ORR: ctrl.alu_op = ALU_ORR;
      default: ctrl.alu_op = ALU_ADD;  // Also address add for LDUR/STUR
    endcase
  end

  // Load in execute feeds this instruction
  assign stall = if_valid && ex_is_load && ex_load_rd != reg_idx_t'(`CPU_XZR) &&
                 ((reads_rn && rn_idx == ex_load_rd) ||
                  (reads_rm && rm_idx == ex_load_rd));

  always_comb begin
    id_ex_d.valid   = if_valid && !stall;
    id_ex_d.ctrl    = id_ex_d.valid ? ctrl : '0;
    id_ex_d.rn_data = rn_data;
    id_ex_d.rm_data = rm_data;
    id_ex_d.imm     = imm;
    id_ex_d.rd      = if_instr[4:0];
    id_ex_d.rn_idx  = rn_idx;
    id_ex_d.rm_idx  = rm_idx;
  end

  always_ff @(posedge CLOCK) begin
    if (RESET) begin
      id_ex.valid <= 1'b0;
      id_ex.ctrl  <= '0;
    end else begin
      id_ex <= id_ex_d;
    end
  end

endmodule

// File: reg_file.sv
`timescale 1ns/10ps

`include "cpu_params.svh"

module reg_file import cpu_pkg::*; (
  input  logic     CLOCK,
  input  logic     RESET,
  input  reg_idx_t rd_a,
  input  reg_idx_t rd_b,
  input  wb_t      wb,
  output word_t    data_a,
  output word_t    data_b
);

  word_t regs [`CPU_NREGS];
  word_t rd_val_a;
  word_t rd_val_b;

  // Same-cycle writeback is passed to the reader
  function automatic word_t read_port(input reg_idx_t idx);
    word_t val;
    if (idx == reg_idx_t'(`CPU_XZR))
      val = '0;
    else if (wb.reg_write && wb.rd == idx)
      val = wb.data;
    else
      val = regs[idx];
    return val;
  endfunction

  always_comb begin
    rd_val_a = read_port(rd_a);
    rd_val_b = read_port(rd_b);
  end

  assign data_a = rd_val_a;
  assign data_b = rd_val_b;

  always_ff @(posedge CLOCK) begin
    if (RESET) begin
      for (int i = 0; i < `CPU_NREGS; i++)
        regs[i] <= word_t'(i);  // Register i starts at i
    end else if (wb.reg_write && wb.rd != reg_idx_t'(`CPU_XZR)) begin
      regs[wb.rd] <= wb.data;
    end
  end

endmodule

// File: cpu_fetch.sv
`timescale 1ns/10ps

module cpu_fetch import cpu_pkg::*; (
  input  logic   CLOCK,
  input  logic   RESET,
  input  instr_t instr,
  input  logic   instr_valid,
  input  logic   stall,
  output word_t  pc,
  output logic   fetch_ready,
  output instr_t if_instr,
  output logic   if_valid
);

  assign fetch_ready = ~stall;

  always_ff @(posedge CLOCK) begin
    if (RESET) begin
      pc       <= '0;
      if_valid <= 1'b0;
    end else if (!stall) begin  // Stall holds PC and IF/ID
      if (instr_valid) begin
        pc       <= pc + word_t'(4);
        if_instr <= instr;
        if_valid <= 1'b1;
      end else begin
        if_valid <= 1'b0;       // Bubble
      end
    end
  end

endmodule

// File: cpu_pkg.sv
package cpu_pkg;

  `include "cpu_params.svh"

  typedef logic [`CPU_XLEN-1:0]   word_t;
  typedef logic [`CPU_ILEN-1:0]   instr_t;
  typedef logic [`CPU_RIDX_W-1:0] reg_idx_t;
  typedef logic [`CPU_OPC_W-1:0]  opcode_t;

  typedef enum logic [1:0] {
    ALU_ADD = 2'd0,
    ALU_SUB = 2'd1,
    ALU_AND = 2'd2,
    ALU_ORR = 2'd3
  } alu_op_e;

  typedef struct packed {
    alu_op_e alu_op;
    logic    use_imm;     // Second operand is the D-type offset
    logic    mem_read;
    logic    mem_write;
    logic    reg_write;
    logic    mem_to_reg;
  } ctrl_t;

  typedef struct packed {
    logic     valid;
    ctrl_t    ctrl;
    word_t    rn_data;
    word_t    rm_data;    // Rm or Rt for a store
    word_t    imm;
    reg_idx_t rd;
    reg_idx_t rn_idx;
    reg_idx_t rm_idx;
  } id_ex_t;

  typedef struct packed {
    word_t addr;          // ALU result forwarded from the memory stage
    word_t wdata;
    logic  read;
    logic  write;
  } mem_req_t;

  typedef struct packed {
    logic     reg_write;
    reg_idx_t rd;
    word_t    data;
  } wb_t;

endpackage

// File: cpu_params.svh
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

`define CPU_XLEN   64  // Data and address width
`define CPU_NREGS  32
`define CPU_RIDX_W 5
`define CPU_ILEN   32
`define CPU_OPC_W  11  // Bits 31:21 of the instruction

// Zero register reads as 0 and drops writes
`define CPU_XZR    31

`endif
